// File: axi_lite_xbar.f
logic/axi_lite_xbar_pkg.sv
logic/xbar_addr_arbiter.sv
logic/xbar_write_router.sv
logic/xbar_read_router.sv
logic/axi_lite_xbar.sv
tb/xbar_slave_model.sv
tb/tb_axi_lite_xbar.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_axi_lite_xbar \
    -f axi_lite_xbar.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

// File: tb/tb_axi_lite_xbar.sv
//--------------------------------------------------------------------------
// Directed tests for the 2x4 crossbar. Each master runs one transaction
// per call; expected read data comes from a local shadow of the slaves.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_axi_lite_xbar;
    import axi_lite_xbar_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic ACLK;
    logic ARESETN;
    logic [1:0] slv_delay;
    integer seed;
    int cycles;
    int error_count;
    int aw_order [$];
    int ar_order [$];
    logic [31:0] shadow [NUM_SLAVES][16];

    lite_addr_t m_aw [NUM_MASTERS];
    lite_w_t    m_w [NUM_MASTERS];
    logic [1:0] m_b_resp [NUM_MASTERS];
    lite_addr_t m_ar [NUM_MASTERS];
    lite_r_t    m_r [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] m_aw_valid, m_aw_ready, m_w_valid, m_w_ready;
    logic [NUM_MASTERS-1:0] m_b_valid, m_b_ready, m_ar_valid, m_ar_ready;
    logic [NUM_MASTERS-1:0] m_r_valid, m_r_ready;

    lite_addr_t s_aw [NUM_SLAVES];
    lite_w_t    s_w [NUM_SLAVES];
    logic [1:0] s_b_resp [NUM_SLAVES];
    lite_addr_t s_ar [NUM_SLAVES];
    lite_r_t    s_r [NUM_SLAVES];
    logic [NUM_SLAVES-1:0] s_aw_valid, s_aw_ready, s_w_valid, s_w_ready;
    logic [NUM_SLAVES-1:0] s_b_valid, s_b_ready, s_ar_valid, s_ar_ready;
    logic [NUM_SLAVES-1:0] s_r_valid, s_r_ready;

    axi_lite_xbar uut (.*);

    xbar_slave_model u_slaves (.delay(slv_delay), .*);

    initial begin
        ACLK = 1'b0;
        forever #2 ACLK = ~ACLK;
    end

    always @(posedge ACLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $fatal(1);
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    function automatic logic [1:0] expected_resp(input int s);
        return (s == 3) ? RESP_SLVERR : RESP_OKAY;
    endfunction

    function automatic logic [31:0] apply_strb(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Master write, with BREADY held low for hold cycles once B is valid
    task automatic write_txn(input int m, input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int hold);
        int s;
        logic got;
        logic [2:0] prot;
        s = int'(addr[31:30]);
        prot = 3'(2 * m + 1);
        slv_delay = 2'($random(seed));
        @(negedge ACLK);
        m_aw[m] = '{addr: addr, prot: prot};
        m_aw_valid[m] = 1'b1;
        got = 1'b0;
        while (!got) begin
            #1;
            got = m_aw_ready[m];
            if (got) begin
                check_eq("s_aw_valid", 32'(s_aw_valid), 32'(1) << s);
                check_eq("s_aw.addr", s_aw[s].addr, addr);
                check_eq("s_aw.prot", 32'(s_aw[s].prot), 32'(prot));
                aw_order.push_back(m);
            end
            @(negedge ACLK);
        end
        m_aw_valid[m] = 1'b0;
        m_w[m] = '{data: data, strb: strb};
        m_w_valid[m] = 1'b1;
        got = 1'b0;
        while (!got) begin
            #1;
            got = m_w_ready[m];
            if (got) begin
                check_eq("s_w_valid", 32'(s_w_valid), 32'(1) << s);
            end
            @(negedge ACLK);
        end
        m_w_valid[m] = 1'b0;
        m_b_ready[m] = (hold == 0);
        got = 1'b0;
        while (!got) begin
            #1;
            got = m_b_valid[m];
            if (!got) begin
                @(negedge ACLK);
            end
        end
        for (int k = 0; k < hold; k++) begin
            check_eq("m_b_valid", 32'(m_b_valid), 32'(1) << m);
            check_eq("m_aw_ready", 32'(m_aw_ready[1-m]), 32'd0);
            @(negedge ACLK);
            m_b_ready[m] = (k == hold - 1);
            #1;
        end
        check_eq("m_b_valid", 32'(m_b_valid), 32'(1) << m);
        check_eq("m_b_resp", 32'(m_b_resp[m]), 32'(expected_resp(s)));
        @(negedge ACLK);
        m_b_ready[m] = 1'b0;
        shadow[s][addr[5:2]] = apply_strb(shadow[s][addr[5:2]], data, strb);
    endtask

    task automatic read_txn(input int m, input logic [31:0] addr);
        int s;
        logic got;
        logic [2:0] prot;
        s = int'(addr[31:30]);
        prot = 3'(2 * m + 1);
        slv_delay = 2'($random(seed));
        @(negedge ACLK);
        m_ar[m] = '{addr: addr, prot: prot};
        m_ar_valid[m] = 1'b1;
        got = 1'b0;
        while (!got) begin
            #1;
            got = m_ar_ready[m];
            if (got) begin
                check_eq("s_ar_valid", 32'(s_ar_valid), 32'(1) << s);
                check_eq("s_ar.addr", s_ar[s].addr, addr);
                check_eq("s_ar.prot", 32'(s_ar[s].prot), 32'(prot));
                ar_order.push_back(m);
            end
            @(negedge ACLK);
        end
        m_ar_valid[m] = 1'b0;
        m_r_ready[m] = 1'b1;
        got = 1'b0;
        while (!got) begin
            #1;
            got = m_r_valid[m];
            if (!got) begin
                @(negedge ACLK);
            end
        end
        check_eq("m_r_valid", 32'(m_r_valid), 32'(1) << m);
        check_eq("m_r.data", m_r[m].data, shadow[s][addr[5:2]]);
        check_eq("m_r.resp", 32'(m_r[m].resp), 32'(expected_resp(s)));
        @(negedge ACLK);
        m_r_ready[m] = 1'b0;
    endtask

    function automatic logic [31:0] make_addr(input int s, input int word);
        return (32'(s) << 30) | (32'(word) << 2);
    endfunction

    //----------------------------------------------------------------------------
    // Directed tests
    //----------------------------------------------------------------------------

    // A lone access after each tie moves the turn, so ties go to both masters
    task automatic test_round_robin();
        for (int rep = 0; rep < 3; rep++) begin
            fork
                write_txn(0, make_addr(rep, 8), 32'h1111_0000 + 32'(rep), 4'hf, 0);
                write_txn(1, make_addr(rep + 1, 9), 32'h2222_0000 + 32'(rep), 4'hf, 0);
            join
            write_txn(rep % 2, make_addr(3 - rep, 10), 32'h3333_0000 + 32'(rep), 4'hf, 0);
            fork
                read_txn(0, make_addr(rep + 1, 9));
                read_txn(1, make_addr(rep, 8));
            join
            read_txn(rep % 2, make_addr(3 - rep, 10));
        end
        for (int k = 0; k < 9; k++) begin
            check_eq("aw_order", 32'(aw_order[k]), 32'(k % 2));
            check_eq("ar_order", 32'(ar_order[k]), 32'(k % 2));
        end
    endtask

    // Both masters touch every slave, responses checked per access
    task automatic test_routing();
        for (int s = 0; s < NUM_SLAVES; s++) begin
            write_txn(0, make_addr(s, s), 32'hA0B0_C000 | 32'(s), 4'hf, 0);
            write_txn(1, make_addr(s, s), 32'h0D0E_0F00 | 32'(s << 4), 4'b0101, 0);
            read_txn(0, make_addr(s, s));
            read_txn(1, make_addr(s, s));
        end
    endtask

    task automatic test_concurrency();
        fork
            write_txn(0, make_addr(1, 7), 32'hCAFE_0107, 4'hf, 0);
            read_txn(1, make_addr(2, 2));
        join
        read_txn(1, make_addr(1, 7));
    endtask

    task automatic test_backpressure();
        int hold;
        int n;
        hold = 2 + int'($unsigned($random(seed)) % 6);
        n = aw_order.size();
        fork
            write_txn(0, make_addr(0, 12), 32'hBEEF_000C, 4'hf, hold);
            begin
                repeat (3) @(negedge ACLK);
                write_txn(1, make_addr(2, 13), 32'hBEEF_100D, 4'hf, 0);
            end
        join
        check_eq("aw_order", 32'(aw_order[n]), 32'd0);
        check_eq("aw_order", 32'(aw_order[n+1]), 32'd1);
        read_txn(1, make_addr(2, 13));
    endtask

    initial begin
        seed = 32'h85c64b94;
        cycles = 0;
        error_count = 0;
        slv_delay = 2'd0;
        ARESETN = 1'b0;
        m_aw_valid = '0;
        m_w_valid = '0;
        m_b_ready = '0;
        m_ar_valid = '0;
        m_r_ready = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_aw[m] = '0;
            m_w[m] = '0;
            m_ar[m] = '0;
        end
        for (int s = 0; s < NUM_SLAVES; s++) begin
            for (int k = 0; k < 16; k++) begin
                shadow[s][k] = 32'h5A5A_0000 | 32'(s * 16 + k);
            end
        end
        repeat (10) @(negedge ACLK);
        ARESETN = 1'b1;
        test_round_robin();
        test_routing();
        test_concurrency();
        test_backpressure();
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tb/xbar_slave_model.sv
//--------------------------------------------------------------------------
// Four AXI4-Lite slaves with 16 words each, indexed by address bits 5:2.
// Slave 3 answers SLVERR. Address ready waits delay cycles after each accept.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module xbar_slave_model (
    input  logic                                     ACLK,
    input  logic                                     ARESETN,
    input  logic [1:0]                               delay,
    input  axi_lite_xbar_pkg::lite_addr_t            s_aw [axi_lite_xbar_pkg::NUM_SLAVES],
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0] s_aw_valid,
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0] s_aw_ready,
    input  axi_lite_xbar_pkg::lite_w_t               s_w [axi_lite_xbar_pkg::NUM_SLAVES],
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0] s_w_valid,
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0] s_w_ready,
    output logic [1:0]                               s_b_resp [axi_lite_xbar_pkg::NUM_SLAVES],
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0] s_b_valid,
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0] s_b_ready,
    input  axi_lite_xbar_pkg::lite_addr_t            s_ar [axi_lite_xbar_pkg::NUM_SLAVES],
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0] s_ar_valid,
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0] s_ar_ready,
    output axi_lite_xbar_pkg::lite_r_t               s_r [axi_lite_xbar_pkg::NUM_SLAVES],
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0] s_r_valid,
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0] s_r_ready
);
    import axi_lite_xbar_pkg::*;

    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave
        logic [DATA_WIDTH-1:0] mem [16];
        logic [1:0]            aw_cnt;
        logic [1:0]            ar_cnt;
        logic                  aw_q;
        logic                  b_q;
        logic                  r_q;
        logic [3:0]            aw_idx;
        logic [DATA_WIDTH-1:0] r_data;
        logic [1:0]            resp;

        assign resp          = (i == 3) ? RESP_SLVERR : RESP_OKAY;
        assign s_aw_ready[i] = !aw_q && !b_q && (aw_cnt == 2'd0);
        assign s_w_ready[i]  = aw_q && !b_q;
        assign s_b_valid[i]  = b_q;
        assign s_b_resp[i]   = resp;
        assign s_ar_ready[i] = !r_q && (ar_cnt == 2'd0);
        assign s_r_valid[i]  = r_q;
        assign s_r[i]        = '{data: r_data, resp: resp};

        always_ff @(posedge ACLK or negedge ARESETN) begin
            if (!ARESETN) begin
                // Fill word depends on slave and word index
                for (int k = 0; k < 16; k++) begin
                    mem[k] <= 32'h5A5A_0000 | 32'(i * 16 + k);
                end
                aw_cnt <= 2'd0;
                ar_cnt <= 2'd0;
                aw_q   <= 1'b0;
                b_q    <= 1'b0;
                r_q    <= 1'b0;
                aw_idx <= 4'd0;
                r_data <= '0;
            end else begin
                if (s_aw_valid[i] && aw_cnt != 2'd0) begin
                    aw_cnt <= aw_cnt - 2'd1;
                end
                if (s_aw_valid[i] && s_aw_ready[i]) begin
                    aw_q   <= 1'b1;
                    aw_idx <= s_aw[i].addr[5:2];
                    aw_cnt <= delay;
                end
                if (s_w_valid[i] && s_w_ready[i]) begin
                    for (int b = 0; b < STRB_WIDTH; b++) begin
                        if (s_w[i].strb[b]) begin
                            mem[aw_idx][8*b +: 8] <= s_w[i].data[8*b +: 8];
                        end
                    end
                    aw_q <= 1'b0;
                    b_q  <= 1'b1;
                end
                if (b_q && s_b_ready[i]) begin
                    b_q <= 1'b0;
                end
                if (s_ar_valid[i] && ar_cnt != 2'd0) begin
                    ar_cnt <= ar_cnt - 2'd1;
                end
                if (s_ar_valid[i] && s_ar_ready[i]) begin
                    r_q    <= 1'b1;
                    r_data <= mem[s_ar[i].addr[5:2]];
                    ar_cnt <= delay;
                end
                if (r_q && s_r_ready[i]) begin
                    r_q <= 1'b0;
                end
            end
        end
    end

endmodule

// File: logic/axi_lite_xbar.sv
//--------------------------------------------------------------------------
// 2x4 AXI4-Lite crossbar with round-robin arbitration and one write plus
// one read in flight. Payloads are broadcast to all slaves.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module axi_lite_xbar (
    input  logic                                      ACLK,
    input  logic                                      ARESETN,

    // Master side
    input  axi_lite_xbar_pkg::lite_addr_t             m_aw [axi_lite_xbar_pkg::NUM_MASTERS],
    input  logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_aw_valid,
    output logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_aw_ready,
    input  axi_lite_xbar_pkg::lite_w_t                m_w [axi_lite_xbar_pkg::NUM_MASTERS],
    input  logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_w_valid,
    output logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_w_ready,
    output logic [1:0]                                m_b_resp [axi_lite_xbar_pkg::NUM_MASTERS],
    output logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_b_valid,
    input  logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_b_ready,
    input  axi_lite_xbar_pkg::lite_addr_t             m_ar [axi_lite_xbar_pkg::NUM_MASTERS],
    input  logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_ar_valid,
    output logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_ar_ready,
    output axi_lite_xbar_pkg::lite_r_t                m_r [axi_lite_xbar_pkg::NUM_MASTERS],
    output logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_r_valid,
    input  logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_r_ready,

    // Slave side
    output axi_lite_xbar_pkg::lite_addr_t             s_aw [axi_lite_xbar_pkg::NUM_SLAVES],
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_aw_valid,
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_aw_ready,
    output axi_lite_xbar_pkg::lite_w_t                s_w [axi_lite_xbar_pkg::NUM_SLAVES],
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_w_valid,
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_w_ready,
    input  logic [1:0]                                s_b_resp [axi_lite_xbar_pkg::NUM_SLAVES],
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_b_valid,
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_b_ready,
    output axi_lite_xbar_pkg::lite_addr_t             s_ar [axi_lite_xbar_pkg::NUM_SLAVES],
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_ar_valid,
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_ar_ready,
    input  axi_lite_xbar_pkg::lite_r_t                s_r [axi_lite_xbar_pkg::NUM_SLAVES],
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_r_valid,
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_r_ready
);
    import axi_lite_xbar_pkg::*;

    // Write direction
    lite_addr_t aw_req;
    logic       aw_accept;
    mst_id_t    aw_mst;
    slv_id_t    aw_slv;
    logic       wr_busy;
    lite_w_t    w_bus;
    logic [1:0] b_resp;

    // Read direction
    lite_addr_t ar_req;
    logic       ar_accept;
    mst_id_t    ar_mst;
    slv_id_t    ar_slv;
    logic       rd_busy;
    lite_r_t    r_bus;

    //----------------------------------------------------------------------
    // Address stages
    //----------------------------------------------------------------------
    xbar_addr_arbiter u_aw_arb (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .busy       (wr_busy),
        .req_valid  (m_aw_valid),
        .req        (m_aw),
        .req_ready  (m_aw_ready),
        .slv_valid  (s_aw_valid),
        .slv_req    (aw_req),
        .slv_ready  (s_aw_ready),
        .accept     (aw_accept),
        .accept_mst (aw_mst),
        .accept_slv (aw_slv)
    );

    xbar_addr_arbiter u_ar_arb (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .busy       (rd_busy),
        .req_valid  (m_ar_valid),
        .req        (m_ar),
        .req_ready  (m_ar_ready),
        .slv_valid  (s_ar_valid),
        .slv_req    (ar_req),
        .slv_ready  (s_ar_ready),
        .accept     (ar_accept),
        .accept_mst (ar_mst),
        .accept_slv (ar_slv)
    );

    //----------------------------------------------------------------------
    // Data and response stages
    //----------------------------------------------------------------------
    xbar_write_router u_wr_route (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .accept     (aw_accept),
        .accept_mst (aw_mst),
        .accept_slv (aw_slv),
        .busy       (wr_busy),
        .m_w_valid  (m_w_valid),
        .m_w        (m_w),
        .m_w_ready  (m_w_ready),
        .s_w_valid  (s_w_valid),
        .s_w        (w_bus),
        .s_w_ready  (s_w_ready),
        .s_b_valid  (s_b_valid),
        .s_b_resp   (s_b_resp),
        .s_b_ready  (s_b_ready),
        .m_b_valid  (m_b_valid),
        .m_b_resp   (b_resp),
        .m_b_ready  (m_b_ready)
    );

    xbar_read_router u_rd_route (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .accept     (ar_accept),
        .accept_mst (ar_mst),
        .accept_slv (ar_slv),
        .busy       (rd_busy),
        .s_r_valid  (s_r_valid),
        .s_r        (s_r),
        .s_r_ready  (s_r_ready),
        .m_r_valid  (m_r_valid),
        .m_r        (r_bus),
        .m_r_ready  (m_r_ready)
    );

    // Broadcast payloads
    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slv_fanout
        assign s_aw[i] = aw_req;
        assign s_w[i]  = w_bus;
        assign s_ar[i] = ar_req;
    end

    for (genvar j = 0; j < NUM_MASTERS; j++) begin : g_mst_fanout
        assign m_b_resp[j] = b_resp;
        assign m_r[j]      = r_bus;
    end

endmodule

// File: logic/xbar_read_router.sv
//--------------------------------------------------------------------------
// One open read at a time. The single R handshake closes it.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module xbar_read_router (
    input  logic                                      ACLK,
    input  logic                                      ARESETN,
    input  logic                                      accept,
    input  axi_lite_xbar_pkg::mst_id_t                accept_mst,
    input  axi_lite_xbar_pkg::slv_id_t                accept_slv,
    output logic                                      busy,
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_r_valid,
    input  axi_lite_xbar_pkg::lite_r_t                s_r [axi_lite_xbar_pkg::NUM_SLAVES],
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_r_ready,
    output logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_r_valid,
    output axi_lite_xbar_pkg::lite_r_t                m_r,
    input  logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_r_ready
);
    import axi_lite_xbar_pkg::*;

    logic    busy_q;
    mst_id_t own_mst_q;
    slv_id_t own_slv_q;
    logic    r_fire;

    assign r_fire = busy_q && s_r_valid[own_slv_q] && m_r_ready[own_mst_q];
    assign busy   = busy_q;

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            busy_q    <= 1'b0;
            own_mst_q <= 1'b0;
            own_slv_q <= '0;
        end else if (accept) begin
            busy_q    <= 1'b1;
            own_mst_q <= accept_mst;
            own_slv_q <= accept_slv;
        end else if (r_fire) begin
            busy_q <= 1'b0;
        end
    end

    // R steering
    always_comb begin
        s_r_ready = '0;
        m_r_valid = '0;
        m_r_valid[own_mst_q] = busy_q && s_r_valid[own_slv_q];
        s_r_ready[own_slv_q] = busy_q && m_r_ready[own_mst_q];
    end

    assign m_r = s_r[own_slv_q];

    // The AR arbiter must hold off while a read is open
    a_no_accept_busy: assert property (@(posedge ACLK) disable iff (!ARESETN)
        accept |-> !busy_q);

endmodule

// File: logic/xbar_write_router.sv
//--------------------------------------------------------------------------
// One open write at a time. W is forwarded once per write, B closes it.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module xbar_write_router (
    input  logic                                      ACLK,
    input  logic                                      ARESETN,
    input  logic                                      accept,
    input  axi_lite_xbar_pkg::mst_id_t                accept_mst,
    input  axi_lite_xbar_pkg::slv_id_t                accept_slv,
    output logic                                      busy,
    input  logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_w_valid,
    input  axi_lite_xbar_pkg::lite_w_t                m_w [axi_lite_xbar_pkg::NUM_MASTERS],
    output logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_w_ready,
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_w_valid,
    output axi_lite_xbar_pkg::lite_w_t                s_w,
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_w_ready,
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_b_valid,
    input  logic [1:0]                                s_b_resp [axi_lite_xbar_pkg::NUM_SLAVES],
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  s_b_ready,
    output logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_b_valid,
    output logic [1:0]                                m_b_resp,
    input  logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] m_b_ready
);
    import axi_lite_xbar_pkg::*;

    logic    busy_q;
    logic    w_done_q;
    mst_id_t own_mst_q;
    slv_id_t own_slv_q;
    logic    w_open;
    logic    w_fire;
    logic    b_fire;

    // W stays connected only until its one beat is taken
    assign w_open = busy_q && !w_done_q;
    assign w_fire = w_open && m_w_valid[own_mst_q] && s_w_ready[own_slv_q];
    assign b_fire = busy_q && s_b_valid[own_slv_q] && m_b_ready[own_mst_q];

    assign busy = busy_q;

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            busy_q    <= 1'b0;
            w_done_q  <= 1'b0;
            own_mst_q <= 1'b0;
            own_slv_q <= '0;
        end else if (accept) begin
            busy_q    <= 1'b1;
            w_done_q  <= 1'b0;
            own_mst_q <= accept_mst;
            own_slv_q <= accept_slv;
        end else begin
            if (b_fire) begin
                busy_q <= 1'b0;
            end
            if (w_fire) begin
                w_done_q <= 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // W and B steering
    //----------------------------------------------------------------------
    always_comb begin
        s_w_valid = '0;
        m_w_ready = '0;
        s_b_ready = '0;
        m_b_valid = '0;
        s_w_valid[own_slv_q] = w_open && m_w_valid[own_mst_q];
        m_w_ready[own_mst_q] = w_open && s_w_ready[own_slv_q];
        m_b_valid[own_mst_q] = busy_q && s_b_valid[own_slv_q];
        s_b_ready[own_slv_q] = busy_q && m_b_ready[own_mst_q];
    end

    assign s_w      = m_w[own_mst_q];
    assign m_b_resp = s_b_resp[own_slv_q];

    // The AW arbiter must hold off while a write is open
    a_no_accept_busy: assert property (@(posedge ACLK) disable iff (!ARESETN)
        accept |-> !busy_q);

endmodule

// File: logic/xbar_addr_arbiter.sv
//--------------------------------------------------------------------------
// Round-robin grant for one address channel. Requests are ignored while busy.
// A grant shown to a slave is held until that slave accepts it.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module xbar_addr_arbiter (
    input  logic                                      ACLK,
    input  logic                                      ARESETN,
    input  logic                                      busy,
    input  logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] req_valid,
    input  axi_lite_xbar_pkg::lite_addr_t             req [axi_lite_xbar_pkg::NUM_MASTERS],
    output logic [axi_lite_xbar_pkg::NUM_MASTERS-1:0] req_ready,
    output logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  slv_valid,
    output axi_lite_xbar_pkg::lite_addr_t             slv_req,
    input  logic [axi_lite_xbar_pkg::NUM_SLAVES-1:0]  slv_ready,
    output logic                                      accept,
    output axi_lite_xbar_pkg::mst_id_t                accept_mst,
    output axi_lite_xbar_pkg::slv_id_t                accept_slv
);
    import axi_lite_xbar_pkg::*;

    logic [NUM_MASTERS-1:0] req_open;
    logic                   grant_vld;
    mst_id_t                grant_mst;
    slv_id_t                grant_slv;

    // Turn holds the master that wins a tie
    mst_id_t                turn_q;
    logic                   lock_q;
    mst_id_t                lock_mst_q;

    assign req_open = busy ? '0 : req_valid;

    //----------------------------------------------------------------------
    // Grant selection
    //----------------------------------------------------------------------
    always_comb begin
        if (lock_q) begin
            // Stay on the master already presented to a slave
            grant_mst = lock_mst_q;
        end else if (&req_open) begin
            grant_mst = turn_q;
        end else begin
            grant_mst = req_open[1];
        end
        grant_vld = req_open[grant_mst];
    end

    // Payload is broadcast, only valid is steered
    assign slv_req   = req[grant_mst];
    assign grant_slv = slv_req.addr[ADDR_WIDTH-1 -: SLV_SEL_WIDTH];

    assign accept     = grant_vld && slv_ready[grant_slv];
    assign accept_mst = grant_mst;
    assign accept_slv = grant_slv;

    always_comb begin
        slv_valid = '0;
        req_ready = '0;
        slv_valid[grant_slv] = grant_vld;
        req_ready[grant_mst] = accept;
    end

    //----------------------------------------------------------------------
    // Turn and lock state
    //----------------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            turn_q     <= 1'b0;
            lock_q     <= 1'b0;
            lock_mst_q <= 1'b0;
        end else begin
            lock_q     <= grant_vld && !accept;
            lock_mst_q <= grant_mst;
            if (accept) begin
                turn_q <= ~grant_mst;
            end
        end
    end

    // At most one master sees ready in a cycle
    a_ready_onehot: assert property (@(posedge ACLK) disable iff (!ARESETN)
        $onehot0(req_ready));

    // A pending slave valid stays on the same slave until accepted
    a_valid_held: assert property (@(posedge ACLK) disable iff (!ARESETN)
        (grant_vld && !accept) |=> (slv_valid == $past(slv_valid)));

endmodule

// File: logic/axi_lite_xbar_pkg.sv
//--------------------------------------------------------------------------
// Widths and counts are fixed for a 2-master, 4-slave AXI4-Lite crossbar.
// The slave index is taken from the top SLV_SEL_WIDTH address bits.
//--------------------------------------------------------------------------
package axi_lite_xbar_pkg;

    localparam int ADDR_WIDTH    = 32;
    localparam int DATA_WIDTH    = 32;
    localparam int STRB_WIDTH    = DATA_WIDTH / 8;

    localparam int NUM_MASTERS   = 2;
    localparam int NUM_SLAVES    = 4;
    localparam int SLV_SEL_WIDTH = 2;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef logic                     mst_id_t;
    typedef logic [SLV_SEL_WIDTH-1:0] slv_id_t;

    //----------------------------------------------------------------------
    // Channel payloads
    //----------------------------------------------------------------------

    // Shared by AW and AR
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [2:0]            prot;
    } lite_addr_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } lite_w_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
    } lite_r_t;

endpackage
